//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

   // datapath sizes
   localparam int DataWidth    = 32;
   localparam int RegAddrWidth = 5;

   // major opcodes, bits 30 to 25
   localparam int OpHi = 30;
   localparam int OpLo = 25;

   localparam logic [5:0] OpAluGroup = 6'b100000;
   localparam logic [5:0] OpAddi     = 6'b101000;
   localparam logic [5:0] OpOri      = 6'b101100;
   localparam logic [5:0] OpXori     = 6'b101011;
   localparam logic [5:0] OpMovi     = 6'b100010;
   localparam logic [5:0] OpMemGroup = 6'b011100;
   localparam logic [5:0] OpLwi      = 6'b000010;
   localparam logic [5:0] OpSwi      = 6'b001010;
   localparam logic [5:0] OpBrGroup  = 6'b100110;
   localparam logic [5:0] OpBrzGroup = 6'b100111;
   localparam logic [5:0] OpJump     = 6'b100100;

   // alu group, bits 4 to 0
   localparam logic [4:0] SubAdd   = 5'b00000;
   localparam logic [4:0] SubSub   = 5'b00001;
   localparam logic [4:0] SubAnd   = 5'b00010;
   localparam logic [4:0] SubXor   = 5'b00011;
   localparam logic [4:0] SubOr    = 5'b00100;
   localparam logic [4:0] SubSlli  = 5'b01000;
   localparam logic [4:0] SubSrli  = 5'b01001;
   localparam logic [4:0] SubRotri = 5'b01011;

   // memory group, bits 7 to 0
   localparam logic [7:0] SubLw = 8'b00000010;
   localparam logic [7:0] SubSw = 8'b00001010;

   // branch groups
   localparam int         BrSubBit  = 14;
   localparam logic       SubBeq    = 1'b0;
   localparam logic       SubBne    = 1'b1;
   localparam int         BrzSubHi  = 19;
   localparam int         BrzSubLo  = 16;
   localparam logic [3:0] SubBeqz   = 4'b0010;
   localparam logic [3:0] SubBnez   = 4'b0011;

   // register and shift fields
   localparam int RtHi = 24;
   localparam int RtLo = 20;
   localparam int RaHi = 19;
   localparam int RaLo = 15;
   localparam int RbHi = 14;
   localparam int RbLo = 10;
   localparam int SvHi = 9;
   localparam int SvLo = 8;

endpackage

`default_nettype wire

//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

   // operation handed to execute
   typedef enum logic [3:0] {
      AluNop,
      AluAdd,
      AluSub,
      AluAnd,
      AluOr,
      AluXor,
      AluSlli,
      AluSrli,
      AluRotri,
      AluMem,
      AluMemImm,
      AluBeq,
      AluBne,
      AluBeqz,
      AluBnez,
      AluJump
   } aluOpT;

   // where operand B comes from
   typedef enum logic [1:0] {
      OpBReg,
      OpBRegShift,
      OpBImm
   } opBSrcT;

   // immediate extension kinds
   typedef enum logic [2:0] {
      ImmNone,
      ImmShamt5Z,
      Imm15S,
      Imm15Z,
      Imm15ZW,
      Imm20S
   } immKindT;

   typedef enum logic [2:0] {
      BrNone,
      BrBeq,
      BrBne,
      BrBeqz,
      BrBnez,
      BrJump
   } branchKindT;

endpackage

`default_nettype wire

//--- src/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder
   import isaPkg::*;
   import ctrlPkg::*;
(
   input  logic [DataWidth-1:0]    inst_i,
   output logic                    legal_o,
   output aluOpT                   aluOp_o,
   output opBSrcT                  opBSrc_o,
   output immKindT                 immKind_o,
   output branchKindT              branchKind_o,
   output logic                    regWrite_o,
   output logic                    memRead_o,
   output logic                    memWrite_o,
   output logic                    memToReg_o,
   output logic                    moviSel_o,
   output logic [RegAddrWidth-1:0] rdAddrA_o,
   output logic [RegAddrWidth-1:0] rdAddrB_o,
   output logic [RegAddrWidth-1:0] rdAddrStore_o,
   output logic [RegAddrWidth-1:0] writeAddr_o
);

   logic [5:0]              opcode;
   logic [4:0]              aluSub;
   logic [7:0]              memSub;
   logic                    brSub;
   logic [3:0]              brzSub;
   logic [RegAddrWidth-1:0] rt;
   logic [RegAddrWidth-1:0] ra;
   logic [RegAddrWidth-1:0] rb;

   assign opcode = inst_i[OpHi:OpLo];
   assign aluSub = inst_i[4:0];
   assign memSub = inst_i[7:0];
   assign brSub  = inst_i[BrSubBit];
   assign brzSub = inst_i[BrzSubHi:BrzSubLo];
   assign rt     = inst_i[RtHi:RtLo];
   assign ra     = inst_i[RaHi:RaLo];
   assign rb     = inst_i[RbHi:RbLo];

   always_comb begin
      // defaults describe an illegal-safe bubble with plain field routing
      legal_o       = 1'b1;
      aluOp_o       = AluNop;
      opBSrc_o      = OpBReg;
      immKind_o     = ImmNone;
      branchKind_o  = BrNone;
      regWrite_o    = 1'b0;
      memRead_o     = 1'b0;
      memWrite_o    = 1'b0;
      memToReg_o    = 1'b0;
      moviSel_o     = 1'b0;
      rdAddrA_o     = ra;
      rdAddrB_o     = rb;
      rdAddrStore_o = rt;
      writeAddr_o   = rt;

      case (opcode)
         OpAluGroup: begin
            regWrite_o = 1'b1;
            case (aluSub)
               SubAdd: aluOp_o = AluAdd;
               SubSub: aluOp_o = AluSub;
               SubAnd: aluOp_o = AluAnd;
               SubXor: aluOp_o = AluXor;
               SubOr:  aluOp_o = AluOr;
               SubSlli, SubSrli, SubRotri: begin
                  opBSrc_o  = OpBImm;
                  immKind_o = ImmShamt5Z;
                  if (aluSub == SubSlli) begin
                     aluOp_o = AluSlli;
                  end else if (aluSub == SubRotri) begin
                     aluOp_o = AluRotri;
                  end else if (rb == '0) begin
                     // srli by zero is the nop encoding
                     regWrite_o = 1'b0;
                  end else begin
                     aluOp_o = AluSrli;
                  end
               end
               default: begin
                  legal_o    = 1'b0;
                  regWrite_o = 1'b0;
               end
            endcase
         end
         OpAddi, OpOri, OpXori: begin
            regWrite_o = 1'b1;
            opBSrc_o   = OpBImm;
            if (opcode == OpAddi) begin
               aluOp_o   = AluAdd;
               immKind_o = Imm15S;
            end else begin
               aluOp_o   = (opcode == OpOri) ? AluOr : AluXor;
               immKind_o = Imm15Z;
            end
         end
         OpMovi: begin
            regWrite_o = 1'b1;
            moviSel_o  = 1'b1;
            opBSrc_o   = OpBImm;
            immKind_o  = Imm20S;
         end
         OpMemGroup: begin
            aluOp_o  = AluMem;
            opBSrc_o = OpBRegShift;
            case (memSub)
               SubLw: begin
                  regWrite_o = 1'b1;
                  memRead_o  = 1'b1;
                  memToReg_o = 1'b1;
               end
               SubSw: memWrite_o = 1'b1;
               default: begin
                  legal_o  = 1'b0;
                  aluOp_o  = AluNop;
                  opBSrc_o = OpBReg;
               end
            endcase
         end
         OpLwi: begin
            aluOp_o    = AluMemImm;
            opBSrc_o   = OpBImm;
            immKind_o  = Imm15ZW;
            regWrite_o = 1'b1;
            memRead_o  = 1'b1;
            memToReg_o = 1'b1;
         end
         OpSwi: begin
            aluOp_o    = AluMemImm;
            opBSrc_o   = OpBImm;
            immKind_o  = Imm15ZW;
            memWrite_o = 1'b1;
         end
         OpBrGroup: begin
            // compare rt against ra
            rdAddrA_o = rt;
            rdAddrB_o = ra;
            if (brSub == SubBeq) begin
               aluOp_o      = AluBeq;
               branchKind_o = BrBeq;
            end else begin
               aluOp_o      = AluBne;
               branchKind_o = BrBne;
            end
         end
         OpBrzGroup: begin
            rdAddrA_o = rt;
            case (brzSub)
               SubBeqz: begin
                  aluOp_o      = AluBeqz;
                  branchKind_o = BrBeqz;
               end
               SubBnez: begin
                  aluOp_o      = AluBnez;
                  branchKind_o = BrBnez;
               end
               default: legal_o = 1'b0;
            endcase
         end
         OpJump: begin
            aluOp_o      = AluJump;
            opBSrc_o     = OpBImm;
            branchKind_o = BrJump;
         end
         default: legal_o = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen
   import isaPkg::*;
   import ctrlPkg::*;
(
   input  logic [DataWidth-1:0] inst_i,
   input  immKindT              immKind_i,
   input  branchKindT           branchKind_i,
   output logic [DataWidth-1:0] imm_o,
   output logic [DataWidth-1:0] branchOffset_o
);

   // operand immediate
   always_comb begin
      case (immKind_i)
         ImmShamt5Z: imm_o = {{(DataWidth-5){1'b0}}, inst_i[RbHi:RbLo]};
         Imm15S:     imm_o = {{(DataWidth-15){inst_i[14]}}, inst_i[14:0]};
         Imm15Z:     imm_o = {{(DataWidth-15){1'b0}}, inst_i[14:0]};
         // word-scaled offset for lwi and swi
         Imm15ZW:    imm_o = {{(DataWidth-17){1'b0}}, inst_i[14:0], 2'b00};
         Imm20S:     imm_o = {{(DataWidth-20){inst_i[19]}}, inst_i[19:0]};
         default:    imm_o = '0;
      endcase
   end

   // halfword branch offsets, lowest bit dropped
   always_comb begin
      case (branchKind_i)
         BrBeq, BrBne: begin
            branchOffset_o = {{(DataWidth-13){inst_i[13]}}, inst_i[13:1]};
         end
         BrBeqz, BrBnez: begin
            branchOffset_o = {{(DataWidth-15){inst_i[15]}}, inst_i[15:1]};
         end
         BrJump: begin
            branchOffset_o = {{(DataWidth-23){inst_i[23]}}, inst_i[23:1]};
         end
         default: branchOffset_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile #(
   parameter int DataWidth    = 32,
   parameter int RegAddrWidth = 5
) (
   input  logic                    clk_i,
   input  logic                    wrEn_i,
   input  logic [RegAddrWidth-1:0] wrAddr_i,
   input  logic [DataWidth-1:0]    wrData_i,
   input  logic [RegAddrWidth-1:0] rdAddrA_i,
   input  logic [RegAddrWidth-1:0] rdAddrB_i,
   input  logic [RegAddrWidth-1:0] rdAddrStore_i,
   output logic [DataWidth-1:0]    rdDataA_o,
   output logic [DataWidth-1:0]    rdDataB_o,
   output logic [DataWidth-1:0]    rdDataStore_o
);

   logic [DataWidth-1:0] regs [2**RegAddrWidth];

   // r0 is writable like any other entry
   always_ff @(posedge clk_i) begin
      if (wrEn_i) begin
         regs[wrAddr_i] <= wrData_i;
      end
   end

   // no write bypass
   assign rdDataA_o     = regs[rdAddrA_i];
   assign rdDataB_o     = regs[rdAddrB_i];
   assign rdDataStore_o = regs[rdAddrStore_i];

endmodule

`default_nettype wire

//--- src/issueLatch.sv
`timescale 1ns/1ps
`default_nettype none

module issueLatch
   import ctrlPkg::*;
#(
   parameter int DataWidth    = 32,
   parameter int RegAddrWidth = 5
) (
   input  logic                    clk_i,
   input  logic                    rstN_i,
   input  logic                    instValid_i,
   input  logic                    legal_i,
   input  aluOpT                   aluOp_i,
   input  opBSrcT                  opBSrc_i,
   input  branchKindT              branchKind_i,
   input  logic                    regWrite_i,
   input  logic                    memRead_i,
   input  logic                    memWrite_i,
   input  logic                    memToReg_i,
   input  logic                    moviSel_i,
   input  logic [RegAddrWidth-1:0] writeAddr_i,
   input  logic [1:0]              sv_i,
   input  logic [DataWidth-1:0]    imm_i,
   input  logic [DataWidth-1:0]    branchOffset_i,
   input  logic [DataWidth-1:0]    rdDataA_i,
   input  logic [DataWidth-1:0]    rdDataB_i,
   input  logic [DataWidth-1:0]    rdDataStore_i,
   output logic                    exValid_o,
   output aluOpT                   exAluOp_o,
   output logic [DataWidth-1:0]    exOpA_o,
   output logic [DataWidth-1:0]    exOpB_o,
   output logic [DataWidth-1:0]    exStoreData_o,
   output logic [DataWidth-1:0]    exMoviData_o,
   output logic [RegAddrWidth-1:0] exWriteAddr_o,
   output logic                    exRegWrite_o,
   output logic                    exMemRead_o,
   output logic                    exMemWrite_o,
   output logic                    exMemToReg_o,
   output logic                    exMoviSel_o,
   output branchKindT              exBranchKind_o,
   output logic [DataWidth-1:0]    exBranchOffset_o
);

   logic                 issue;
   logic [DataWidth-1:0] opB;
   logic [DataWidth-1:0] storeData;

   assign issue = instValid_i & legal_i;

   // operand B select
   always_comb begin
      case (opBSrc_i)
         OpBRegShift: opB = rdDataB_i << sv_i;
         OpBImm:      opB = imm_i;
         default:     opB = rdDataB_i;
      endcase
   end

   assign storeData = memWrite_i ? rdDataStore_i : '0;

   // control, bubbles and illegal encodings drop every enable
   always_ff @(posedge clk_i) begin
      if (!rstN_i) begin
         exValid_o      <= 1'b0;
         exAluOp_o      <= AluNop;
         exRegWrite_o   <= 1'b0;
         exMemRead_o    <= 1'b0;
         exMemWrite_o   <= 1'b0;
         exMemToReg_o   <= 1'b0;
         exMoviSel_o    <= 1'b0;
         exBranchKind_o <= BrNone;
      end else begin
         exValid_o      <= instValid_i;
         exAluOp_o      <= issue ? aluOp_i : AluNop;
         exRegWrite_o   <= issue & regWrite_i;
         exMemRead_o    <= issue & memRead_i;
         exMemWrite_o   <= issue & memWrite_i;
         exMemToReg_o   <= issue & memToReg_i;
         exMoviSel_o    <= issue & moviSel_i;
         exBranchKind_o <= issue ? branchKind_i : BrNone;
      end
   end

   // payload
   always_ff @(posedge clk_i) begin
      exOpA_o          <= rdDataA_i;
      exOpB_o          <= opB;
      exStoreData_o    <= storeData;
      exMoviData_o     <= imm_i;
      exWriteAddr_o    <= writeAddr_i;
      exBranchOffset_o <= branchOffset_i;
   end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
   import isaPkg::*;
   import ctrlPkg::*;
(
   input  logic                    clk_i,
   input  logic                    rstN_i,
   input  logic                    instValid_i,
   input  logic [DataWidth-1:0]    inst_i,
   input  logic                    wbEn_i,
   input  logic [RegAddrWidth-1:0] wbAddr_i,
   input  logic [DataWidth-1:0]    wbData_i,
   output logic                    exValid_o,
   output aluOpT                   exAluOp_o,
   output logic [DataWidth-1:0]    exOpA_o,
   output logic [DataWidth-1:0]    exOpB_o,
   output logic [DataWidth-1:0]    exStoreData_o,
   output logic [DataWidth-1:0]    exMoviData_o,
   output logic [RegAddrWidth-1:0] exWriteAddr_o,
   output logic                    exRegWrite_o,
   output logic                    exMemRead_o,
   output logic                    exMemWrite_o,
   output logic                    exMemToReg_o,
   output logic                    exMoviSel_o,
   output branchKindT              exBranchKind_o,
   output logic [DataWidth-1:0]    exBranchOffset_o
);

   logic                    legal;
   aluOpT                   aluOp;
   opBSrcT                  opBSrc;
   immKindT                 immKind;
   branchKindT              branchKind;
   logic                    regWrite;
   logic                    memRead;
   logic                    memWrite;
   logic                    memToReg;
   logic                    moviSel;
   logic [RegAddrWidth-1:0] rdAddrA;
   logic [RegAddrWidth-1:0] rdAddrB;
   logic [RegAddrWidth-1:0] rdAddrStore;
   logic [RegAddrWidth-1:0] writeAddr;
   logic [DataWidth-1:0]    imm;
   logic [DataWidth-1:0]    branchOffset;
   logic [DataWidth-1:0]    rdDataA;
   logic [DataWidth-1:0]    rdDataB;
   logic [DataWidth-1:0]    rdDataStore;

   instDecoder instDecoder_inst (
      .inst_i        (inst_i),
      .legal_o       (legal),
      .aluOp_o       (aluOp),
      .opBSrc_o      (opBSrc),
      .immKind_o     (immKind),
      .branchKind_o  (branchKind),
      .regWrite_o    (regWrite),
      .memRead_o     (memRead),
      .memWrite_o    (memWrite),
      .memToReg_o    (memToReg),
      .moviSel_o     (moviSel),
      .rdAddrA_o     (rdAddrA),
      .rdAddrB_o     (rdAddrB),
      .rdAddrStore_o (rdAddrStore),
      .writeAddr_o   (writeAddr)
   );

   immGen immGen_inst (
      .inst_i         (inst_i),
      .immKind_i      (immKind),
      .branchKind_i   (branchKind),
      .imm_o          (imm),
      .branchOffset_o (branchOffset)
   );

   // write port belongs to writeback
   regFile #(
      .DataWidth    (DataWidth),
      .RegAddrWidth (RegAddrWidth)
   ) regFile_inst (
      .clk_i         (clk_i),
      .wrEn_i        (wbEn_i),
      .wrAddr_i      (wbAddr_i),
      .wrData_i      (wbData_i),
      .rdAddrA_i     (rdAddrA),
      .rdAddrB_i     (rdAddrB),
      .rdAddrStore_i (rdAddrStore),
      .rdDataA_o     (rdDataA),
      .rdDataB_o     (rdDataB),
      .rdDataStore_o (rdDataStore)
   );

   issueLatch #(
      .DataWidth    (DataWidth),
      .RegAddrWidth (RegAddrWidth)
   ) issueLatch_inst (
      .clk_i            (clk_i),
      .rstN_i           (rstN_i),
      .instValid_i      (instValid_i),
      .legal_i          (legal),
      .aluOp_i          (aluOp),
      .opBSrc_i         (opBSrc),
      .branchKind_i     (branchKind),
      .regWrite_i       (regWrite),
      .memRead_i        (memRead),
      .memWrite_i       (memWrite),
      .memToReg_i       (memToReg),
      .moviSel_i        (moviSel),
      .writeAddr_i      (writeAddr),
      .sv_i             (inst_i[SvHi:SvLo]),
      .imm_i            (imm),
      .branchOffset_i   (branchOffset),
      .rdDataA_i        (rdDataA),
      .rdDataB_i        (rdDataB),
      .rdDataStore_i    (rdDataStore),
      .exValid_o        (exValid_o),
      .exAluOp_o        (exAluOp_o),
      .exOpA_o          (exOpA_o),
      .exOpB_o          (exOpB_o),
      .exStoreData_o    (exStoreData_o),
      .exMoviData_o     (exMoviData_o),
      .exWriteAddr_o    (exWriteAddr_o),
      .exRegWrite_o     (exRegWrite_o),
      .exMemRead_o      (exMemRead_o),
      .exMemWrite_o     (exMemWrite_o),
      .exMemToReg_o     (exMemToReg_o),
      .exMoviSel_o      (exMoviSel_o),
      .exBranchKind_o   (exBranchKind_o),
      .exBranchOffset_o (exBranchOffset_o)
   );

endmodule

`default_nettype wire

//--- verif/tbRefModel.svh
// expected decode results for one instruction
typedef struct packed {
   logic        legal;
   aluOpT       aluOp;
   branchKindT  branch;
   logic        regWrite;
   logic        memRead;
   logic        memWrite;
   logic        moviSel;
   logic        chkOpA;
   logic        chkOpB;
   logic [4:0]  wrAddr;
   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] storeData;
   logic [31:0] moviData;
   logic [31:0] offset;
} expT;

// sign extension from the low bits of a word
function automatic logic signed [31:0] signExtend(input logic [31:0] v, input int bits);
   return $signed(v << (32 - bits)) >>> (32 - bits);
endfunction

function automatic expT expectedFor(input logic [31:0] inst, input logic [31:0] rf [32]);
   expT        e;
   logic [5:0] op;
   logic [4:0] rt;
   logic [4:0] ra;
   logic [4:0] rb;
   op = inst[OpHi:OpLo];
   rt = inst[24:20];
   ra = inst[19:15];
   rb = inst[14:10];
   e = '0;
   e.legal = 1'b1;
   e.chkOpA = 1'b1;
   e.chkOpB = 1'b1;
   e.wrAddr = rt;
   e.opA = rf[ra];
   e.opB = rf[rb];
   case (op)
      OpAluGroup: begin
         e.regWrite = 1'b1;
         case (inst[4:0])
            SubAdd:   e.aluOp = AluAdd;
            SubSub:   e.aluOp = AluSub;
            SubAnd:   e.aluOp = AluAnd;
            SubOr:    e.aluOp = AluOr;
            SubXor:   e.aluOp = AluXor;
            SubSlli:  e.aluOp = AluSlli;
            SubRotri: e.aluOp = AluRotri;
            // zero amount means NOP
            SubSrli: begin
               e.aluOp = (rb == 5'd0) ? AluNop : AluSrli;
               e.regWrite = (rb != 5'd0);
            end
            default: e.legal = 1'b0;
         endcase
         if (inst[4:0] inside {SubSlli, SubSrli, SubRotri}) begin
            e.opB = 32'(rb);
         end
      end
      OpAddi: begin
         e.aluOp = AluAdd;
         e.regWrite = 1'b1;
         e.opB = signExtend(inst, 15);
      end
      OpOri, OpXori: begin
         e.aluOp = (op == OpOri) ? AluOr : AluXor;
         e.regWrite = 1'b1;
         e.opB = 32'(inst[14:0]);
      end
      OpMovi: begin
         e.regWrite = 1'b1;
         e.moviSel = 1'b1;
         e.chkOpA = 1'b0;
         e.moviData = signExtend(inst, 20);
         e.opB = e.moviData;
      end
      OpMemGroup: begin
         e.aluOp = AluMem;
         e.opB = rf[rb] << inst[9:8];
         if (inst[7:0] == SubLw) begin
            e.regWrite = 1'b1;
            e.memRead = 1'b1;
         end else if (inst[7:0] == SubSw) begin
            e.memWrite = 1'b1;
            e.storeData = rf[rt];
         end else begin
            e.legal = 1'b0;
         end
      end
      OpLwi, OpSwi: begin
         e.aluOp = AluMemImm;
         e.opB = 32'(inst[14:0]) << 2;
         e.regWrite = (op == OpLwi);
         e.memRead = (op == OpLwi);
         e.memWrite = (op == OpSwi);
         e.storeData = (op == OpSwi) ? rf[rt] : 32'd0;
      end
      OpBrGroup: begin
         e.aluOp = (inst[BrSubBit] == SubBne) ? AluBne : AluBeq;
         e.branch = (inst[BrSubBit] == SubBne) ? BrBne : BrBeq;
         e.opA = rf[rt];
         e.opB = rf[ra];
         e.offset = signExtend(inst, 14) >>> 1;
      end
      OpBrzGroup: begin
         e.opA = rf[rt];
         e.chkOpB = 1'b0;
         e.offset = signExtend(inst, 16) >>> 1;
         case (inst[19:16])
            SubBeqz: begin
               e.aluOp = AluBeqz;
               e.branch = BrBeqz;
            end
            SubBnez: begin
               e.aluOp = AluBnez;
               e.branch = BrBnez;
            end
            default: e.legal = 1'b0;
         endcase
      end
      OpJump: begin
         e.aluOp = AluJump;
         e.branch = BrJump;
         e.chkOpA = 1'b0;
         e.chkOpB = 1'b0;
         e.offset = signExtend(inst, 24) >>> 1;
      end
      default: e.legal = 1'b0;
   endcase
   return e;
endfunction

//--- verif/decodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb
   import isaPkg::*;
   import ctrlPkg::*;
();

   // cycle budget for each of the six tests
   localparam int NumTests   = 6;
   localparam int TestCycles = 40;
   localparam int WatchdogNs = NumTests * TestCycles * 20 * 2;
   localparam logic [4:0] AluSubs [8] = '{SubAdd, SubSub, SubAnd, SubOr, SubXor,
                                          SubSlli, SubSrli, SubRotri};

   logic        clk_i = 1'b0;
   logic        rstN_i;
   logic        instValid_i;
   logic [31:0] inst_i;
   logic        wbEn_i;
   logic [4:0]  wbAddr_i;
   logic [31:0] wbData_i;
   logic        exValid_o;
   aluOpT       exAluOp_o;
   logic [31:0] exOpA_o;
   logic [31:0] exOpB_o;
   logic [31:0] exStoreData_o;
   logic [31:0] exMoviData_o;
   logic [4:0]  exWriteAddr_o;
   logic        exRegWrite_o;
   logic        exMemRead_o;
   logic        exMemWrite_o;
   logic        exMemToReg_o;
   logic        exMoviSel_o;
   branchKindT  exBranchKind_o;
   logic [31:0] exBranchOffset_o;

   `include "tbRefModel.svh"

   logic        armed = 1'b0;
   logic        expValid;
   logic        live;
   expT         cur;
   logic [31:0] shadow [32];
   int          errCount = 0;
   int          testCount = 0;
   int          failCount = 0;
   int          testStartErr = 0;

   decodeStage decodeStage_inst (.*);

   always #10 clk_i = ~clk_i;

   // model and shadow registers update on the same edges as the DUT
   always @(posedge clk_i) begin
      armed    <= 1'b1;
      expValid <= rstN_i & instValid_i;
      cur      <= expectedFor(inst_i, shadow);
      if (wbEn_i) begin
         shadow[wbAddr_i] <= wbData_i;
      end
   end

   assign live = expValid & cur.legal;

   task automatic reportMismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
      errCount++;
      $display("ERROR at time %0t: %s is %h, model expects %h", $time, what, got, want);
   endtask

   aValid: assert property (@(posedge clk_i) armed |-> exValid_o == expValid)
      else reportMismatch("exValid_o", 32'($sampled(exValid_o)), 32'($sampled(expValid)));
   aAluOp: assert property (@(posedge clk_i) armed |-> exAluOp_o == (live ? cur.aluOp : AluNop))
      else reportMismatch("exAluOp_o", 32'($sampled(exAluOp_o)), 32'($sampled(cur.aluOp)));
   aEnables: assert property (@(posedge clk_i) armed |->
         {exRegWrite_o, exMemRead_o, exMemWrite_o, exMemToReg_o, exMoviSel_o} ==
         (live ? {cur.regWrite, cur.memRead, cur.memWrite, cur.memRead, cur.moviSel} : 5'b0))
      else reportMismatch("enables", 32'($sampled(exRegWrite_o)), 32'($sampled(cur.regWrite)));
   aBranch: assert property (@(posedge clk_i) armed |->
         exBranchKind_o == (live ? cur.branch : BrNone))
      else reportMismatch("exBranchKind_o", 32'($sampled(exBranchKind_o)),
                          32'($sampled(cur.branch)));
   aOpA: assert property (@(posedge clk_i) armed && live && cur.chkOpA |-> exOpA_o == cur.opA)
      else reportMismatch("exOpA_o", $sampled(exOpA_o), $sampled(cur.opA));
   aOpB: assert property (@(posedge clk_i) armed && live && cur.chkOpB |-> exOpB_o == cur.opB)
      else reportMismatch("exOpB_o", $sampled(exOpB_o), $sampled(cur.opB));
   aStore: assert property (@(posedge clk_i) armed && live |-> exStoreData_o == cur.storeData)
      else reportMismatch("exStoreData_o", $sampled(exStoreData_o), $sampled(cur.storeData));
   aMovi: assert property (@(posedge clk_i) armed && live && cur.moviSel |->
         exMoviData_o == cur.moviData)
      else reportMismatch("exMoviData_o", $sampled(exMoviData_o), $sampled(cur.moviData));
   aWrAddr: assert property (@(posedge clk_i) armed && live && cur.regWrite |->
         exWriteAddr_o == cur.wrAddr)
      else reportMismatch("exWriteAddr_o", 32'($sampled(exWriteAddr_o)),
                          32'($sampled(cur.wrAddr)));
   aOffset: assert property (@(posedge clk_i) armed && live |-> exBranchOffset_o == cur.offset)
      else reportMismatch("exBranchOffset_o", $sampled(exBranchOffset_o), $sampled(cur.offset));

   // random fields except where the mask pins them
   function automatic logic [31:0] randInst(input logic [5:0] op, input logic [24:0] mask,
                                            input logic [24:0] val);
      logic [24:0] r;
      r = 25'($urandom);
      return {1'b0, op, (r & ~mask) | (val & mask)};
   endfunction

   task automatic sendInst(input logic [31:0] inst);
      instValid_i = 1'b1;
      inst_i = inst;
      @(posedge clk_i);
      #1;
   endtask

   task automatic sendBubbles(input int n);
      instValid_i = 1'b0;
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic fillRegFile();
      for (int i = 0; i < 32; i++) begin
         wbEn_i = 1'b1;
         wbAddr_i = 5'(i);
         wbData_i = $urandom;
         @(posedge clk_i);
         #1;
      end
      wbEn_i = 1'b0;
   endtask

   task automatic closeTest(input string name);
      sendBubbles(2);
      testCount++;
      if (errCount != testStartErr) begin
         failCount++;
      end
      $display("test %0d %s: %s", testCount, name, (errCount == testStartErr) ? "pass" : "fail");
      testStartErr = errCount;
   endtask

   initial begin
      #(WatchdogNs);
      $display("watchdog: the run did not finish within %0d ns", WatchdogNs);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      void'($urandom(60));
      // a valid load and a valid branch during reset must not come through
      rstN_i = 1'b0;
      wbEn_i = 1'b0;
      wbAddr_i = '0;
      wbData_i = '0;
      sendInst(randInst(OpMemGroup, 25'hff, 25'(SubLw)));
      sendInst(randInst(OpBrGroup, 25'h4000, 25'(SubBeq) << BrSubBit));
      rstN_i = 1'b1;
      closeTest("reset and bubble");
      fillRegFile();

      repeat (3) begin
         foreach (AluSubs[i]) sendInst(randInst(OpAluGroup, 25'h1f, 25'(AluSubs[i])));
      end
      sendInst(randInst(OpAluGroup, 25'h7c1f, 25'(SubSrli)));
      closeTest("register and shift ALU");

      repeat (4) begin
         sendInst(randInst(OpAddi, '0, '0));
         sendInst(randInst(OpOri, '0, '0));
         sendInst(randInst(OpXori, '0, '0));
         sendInst(randInst(OpMovi, '0, '0));
      end
      closeTest("immediate ALU");

      repeat (4) begin
         sendInst(randInst(OpMemGroup, 25'hff, 25'(SubLw)));
         sendInst(randInst(OpMemGroup, 25'hff, 25'(SubSw)));
         sendBubbles(1);
         sendInst(randInst(OpLwi, '0, '0));
         sendInst(randInst(OpSwi, '0, '0));
      end
      closeTest("loads and stores");

      repeat (4) begin
         sendInst(randInst(OpBrGroup, 25'h4000, 25'(SubBeq) << BrSubBit));
         sendInst(randInst(OpBrGroup, 25'h4000, 25'(SubBne) << BrSubBit));
         sendInst(randInst(OpBrzGroup, 25'hf0000, 25'(SubBeqz) << BrzSubLo));
         sendInst(randInst(OpBrzGroup, 25'hf0000, 25'(SubBnez) << BrzSubLo));
         sendInst(randInst(OpJump, '0, '0));
      end
      closeTest("branches and jump");

      // unused opcode, then unknown sub-opcodes, then a random sweep
      sendInst(randInst(6'b111111, '0, '0));
      sendInst(randInst(OpAluGroup, 25'h1f, 25'h1f));
      sendInst(randInst(OpMemGroup, 25'hff, 25'hff));
      sendInst(randInst(OpBrzGroup, 25'hf0000, 25'hf0000));
      repeat (8) sendInst($urandom);
      closeTest("illegal encodings");

      $display("%0d tests run, %0d failed, %0d assertion errors", testCount, failCount, errCount);
      if (errCount == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+verif
src/isaPkg.sv
src/ctrlPkg.sv
src/instDecoder.sv
src/immGen.sv
src/regFile.sv
src/issueLatch.sv
src/decodeStage.sv
verif/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench, pass only if the pass line shows up
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module decodeStageTb \
   && ./obj_dir/VdecodeStageTb | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }
